//--- rtl/adam_pkg.sv
// system configuration package: bus structs, register and state encodings, widths
`default_nettype none

package adam_pkg;

    // bus and boot address widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // configuration bus operations
    typedef enum logic {
        CFG_READ  = 1'b0,
        CFG_WRITE = 1'b1
    } cfg_op_e;

    // register offsets inside one unit window, two low word-address bits
    typedef enum logic [1:0] {
        // bit 0 reset request, bit 1 pause request
        REG_CTRL   = 2'd0,
        // read only, bit 0 in reset, bit 1 paused
        REG_STATUS = 2'd1,
        REG_BOOT   = 2'd2,
        // bit 0 enable, bit 1 pending (write 1 to clear)
        REG_IRQ    = 2'd3
    } cfg_reg_e;

    // host request, addr is a word address
    typedef struct packed {
        cfg_op_e op;
        addr_t   addr;
        data_t   wdata;
    } cfg_cmd_t;

    // slave response
    typedef struct packed {
        data_t rdata;
        logic  err;
    } cfg_rsp_t;

    // pause controller states
    typedef enum logic [1:0] {
        ST_RUN      = 2'd0,
        ST_PAUSING  = 2'd1,
        ST_PAUSED   = 2'd2,
        ST_RESUMING = 2'd3
    } pause_state_e;

endpackage

`default_nettype wire

//--- rtl/adam_pause_ctrl.sv
// pause controller: four-phase pause handshake with one unit and reset sequencing
`default_nettype none

module adam_pause_ctrl (
    input  logic clk,
    input  logic arst_n,

    input  logic ctrl_rst,
    input  logic ctrl_pause,

    output logic pause_req,
    input  logic pause_ack,

    output logic unit_rst,
    output logic unit_in_rst,
    output logic unit_paused
);

    adam_pkg::pause_state_e state;
    adam_pkg::pause_state_e state_next;
    logic                   want_pause;

    // a reset request also needs the unit quiescent first
    assign want_pause = ctrl_rst || ctrl_pause;

    always_comb begin
        state_next = state;
        case (state)
            adam_pkg::ST_RUN: begin
                if (want_pause) begin
                    state_next = adam_pkg::ST_PAUSING;
                end
            end
            adam_pkg::ST_PAUSING: begin
                // req stays up until the unit answers
                if (pause_ack) begin
                    state_next = adam_pkg::ST_PAUSED;
                end
            end
            adam_pkg::ST_PAUSED: begin
                if (!want_pause) begin
                    state_next = adam_pkg::ST_RESUMING;
                end
            end
            adam_pkg::ST_RESUMING: begin
                if (!pause_ack) begin
                    state_next = adam_pkg::ST_RUN;
                end
            end
            default: begin
                state_next = adam_pkg::ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= adam_pkg::ST_RUN;
            unit_rst <= 1'b0;
        end else begin
            state    <= state_next;
            // only a paused unit is put into reset
            unit_rst <= (state == adam_pkg::ST_PAUSED) && ctrl_rst;
        end
    end

    assign pause_req = (state == adam_pkg::ST_PAUSING) || (state == adam_pkg::ST_PAUSED);

    // status back to the register file
    assign unit_paused = state == adam_pkg::ST_PAUSED;
    assign unit_in_rst = unit_rst;

endmodule

`default_nettype wire

//--- rtl/adam_irq_ctrl.sv
// interrupt block: sticky per-unit pending bits combined into one host interrupt
`default_nettype none

module adam_irq_ctrl #(
    parameter int NO_UNITS = 4
) (
    input  logic                clk,
    input  logic                arst_n,

    input  logic [NO_UNITS-1:0] unit_irq,
    input  logic [NO_UNITS-1:0] irq_en,
    input  logic [NO_UNITS-1:0] irq_clr,

    output logic [NO_UNITS-1:0] irq_pending,
    output logic                host_irq
);

    logic [NO_UNITS-1:0] pending_next;
    logic [NO_UNITS-1:0] active;

    // a live irq level wins over a clear on the same edge
    assign pending_next = unit_irq | (irq_pending & ~irq_clr);

    // pending and enabled
    assign active = irq_pending & irq_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_pending <= '0;
        end else begin
            irq_pending <= pending_next;
        end
    end

    // one cycle behind the pending bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_irq <= 1'b0;
        end else begin
            host_irq <= |active;
        end
    end

endmodule

`default_nettype wire

//--- rtl/adam_syscfg_regs.sv
// syscfg register file: four-phase config bus slave with per-unit control, boot and irq regs
`default_nettype none

module adam_syscfg_regs #(
    parameter int NO_UNITS = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            cfg_req,
    input  adam_pkg::cfg_cmd_t              cfg_cmd,
    output logic                            cfg_ack,
    output adam_pkg::cfg_rsp_t              cfg_rsp,

    output logic            [NO_UNITS-1:0]  ctrl_rst,
    output logic            [NO_UNITS-1:0]  ctrl_pause,
    input  logic            [NO_UNITS-1:0]  unit_in_rst,
    input  logic            [NO_UNITS-1:0]  unit_paused,
    output adam_pkg::addr_t [NO_UNITS-1:0]  unit_boot_addr,

    output logic            [NO_UNITS-1:0]  irq_en,
    output logic            [NO_UNITS-1:0]  irq_clr,
    input  logic            [NO_UNITS-1:0]  irq_pending
);

    localparam int UNIT_W = adam_pkg::ADDR_WIDTH - 2;

    adam_pkg::cfg_op_e   acc_op;
    adam_pkg::cfg_reg_e  acc_reg;
    logic [UNIT_W-1:0]   acc_unit;
    logic                access;
    logic                bad;
    logic                wr_ok;
    logic [NO_UNITS-1:0] unit_sel;
    adam_pkg::data_t     rd_data;

    // decode of the current request
    assign acc_op   = cfg_cmd.op;
    assign acc_reg  = adam_pkg::cfg_reg_e'(cfg_cmd.addr[1:0]);
    assign acc_unit = cfg_cmd.addr[adam_pkg::ADDR_WIDTH-1:2];

    // request seen while ack is still low starts an access
    assign access = cfg_req && !cfg_ack;

    // unknown unit, or a write to the read-only status word
    assign bad = (acc_unit >= UNIT_W'(NO_UNITS))
              || (acc_op == adam_pkg::CFG_WRITE && acc_reg == adam_pkg::REG_STATUS);

    assign wr_ok = access && acc_op == adam_pkg::CFG_WRITE && !bad;

    for (genvar u = 0; u < NO_UNITS; u++) begin : g_sel
        assign unit_sel[u] = acc_unit == UNIT_W'(u);
        // write-one-to-clear, lands on the same edge as the write
        assign irq_clr[u]  = wr_ok && unit_sel[u] && acc_reg == adam_pkg::REG_IRQ
                          && cfg_cmd.wdata[1];
    end

    // read mux, stays zero when no unit matches
    always_comb begin
        rd_data = '0;
        for (int u = 0; u < NO_UNITS; u++) begin
            if (unit_sel[u]) begin
                case (acc_reg)
                    adam_pkg::REG_CTRL:   rd_data[1:0] = {ctrl_pause[u], ctrl_rst[u]};
                    adam_pkg::REG_STATUS: rd_data[1:0] = {unit_paused[u], unit_in_rst[u]};
                    adam_pkg::REG_BOOT:   rd_data      = adam_pkg::data_t'(unit_boot_addr[u]);
                    adam_pkg::REG_IRQ:    rd_data[1:0] = {irq_pending[u], irq_en[u]};
                    default:              rd_data      = '0;
                endcase
            end
        end
    end

    // bus handshake, response held until the next access
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_ack <= 1'b0;
            cfg_rsp <= '0;
        end else if (access) begin
            cfg_ack       <= 1'b1;
            cfg_rsp.err   <= bad;
            cfg_rsp.rdata <= (acc_op == adam_pkg::CFG_READ) ? rd_data : '0;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    // per-unit writable registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_rst       <= '0;
            ctrl_pause     <= '0;
            irq_en         <= '0;
            unit_boot_addr <= '0;
        end else if (wr_ok) begin
            for (int u = 0; u < NO_UNITS; u++) begin
                if (unit_sel[u]) begin
                    case (acc_reg)
                        adam_pkg::REG_CTRL: begin
                            ctrl_rst[u]   <= cfg_cmd.wdata[0];
                            ctrl_pause[u] <= cfg_cmd.wdata[1];
                        end
                        adam_pkg::REG_BOOT: begin
                            unit_boot_addr[u] <= adam_pkg::addr_t'(cfg_cmd.wdata);
                        end
                        adam_pkg::REG_IRQ: begin
                            irq_en[u] <= cfg_cmd.wdata[0];
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/adam_syscfg.sv
// syscfg top: register file, one pause controller per unit and the interrupt block
`default_nettype none

module adam_syscfg #(
    parameter int NO_UNITS = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            cfg_req,
    input  adam_pkg::cfg_cmd_t              cfg_cmd,
    output logic                            cfg_ack,
    output adam_pkg::cfg_rsp_t              cfg_rsp,

    output logic            [NO_UNITS-1:0]  pause_req,
    input  logic            [NO_UNITS-1:0]  pause_ack,
    output logic            [NO_UNITS-1:0]  unit_rst,
    output adam_pkg::addr_t [NO_UNITS-1:0]  unit_boot_addr,
    input  logic            [NO_UNITS-1:0]  unit_irq,

    output logic                            host_irq
);

    // register file to controllers
    logic [NO_UNITS-1:0] ctrl_rst;
    logic [NO_UNITS-1:0] ctrl_pause;

    // controllers back to status
    logic [NO_UNITS-1:0] unit_in_rst;
    logic [NO_UNITS-1:0] unit_paused;

    // interrupt path
    logic [NO_UNITS-1:0] irq_en;
    logic [NO_UNITS-1:0] irq_clr;
    logic [NO_UNITS-1:0] irq_pending;

    adam_syscfg_regs #(
        .NO_UNITS (NO_UNITS)
    ) u_regs (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_req        (cfg_req),
        .cfg_cmd        (cfg_cmd),
        .cfg_ack        (cfg_ack),
        .cfg_rsp        (cfg_rsp),
        .ctrl_rst       (ctrl_rst),
        .ctrl_pause     (ctrl_pause),
        .unit_in_rst    (unit_in_rst),
        .unit_paused    (unit_paused),
        .unit_boot_addr (unit_boot_addr),
        .irq_en         (irq_en),
        .irq_clr        (irq_clr),
        .irq_pending    (irq_pending)
    );

    for (genvar u = 0; u < NO_UNITS; u++) begin : g_unit
        adam_pause_ctrl u_pause_ctrl (
            .clk         (clk),
            .arst_n      (arst_n),
            .ctrl_rst    (ctrl_rst[u]),
            .ctrl_pause  (ctrl_pause[u]),
            .pause_req   (pause_req[u]),
            .pause_ack   (pause_ack[u]),
            .unit_rst    (unit_rst[u]),
            .unit_in_rst (unit_in_rst[u]),
            .unit_paused (unit_paused[u])
        );
    end

    adam_irq_ctrl #(
        .NO_UNITS (NO_UNITS)
    ) u_irq_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .unit_irq    (unit_irq),
        .irq_en      (irq_en),
        .irq_clr     (irq_clr),
        .irq_pending (irq_pending),
        .host_irq    (host_irq)
    );

endmodule

`default_nettype wire

//--- tests/adam_syscfg_properties.sv
// syscfg assertions: config bus and pause handshakes, reset only while paused
`default_nettype none

module adam_syscfg_properties #(
    parameter int NO_UNITS = 4
) (
    input logic                clk,
    input logic                arst_n,
    input logic                cfg_req,
    input logic                cfg_ack,
    input adam_pkg::cfg_rsp_t  cfg_rsp,
    input logic [NO_UNITS-1:0] pause_req,
    input logic [NO_UNITS-1:0] pause_ack,
    input logic [NO_UNITS-1:0] unit_rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions so far
    int unsigned fail_count = 0;

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(cfg_ack) |-> $past(cfg_req))
        else begin
            fail_count++;
            $error("cfg_ack rose without cfg_req");
        end

    // response held for the whole ack phase
    rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_ack && $past(cfg_ack) |-> $stable(cfg_rsp))
        else begin
            fail_count++;
            $error("cfg_rsp changed while cfg_ack was high");
        end

    for (genvar u = 0; u < NO_UNITS; u++) begin : g_unit
        req_held: assert property (@(posedge clk) disable iff (!arst_n)
            $fell(pause_req[u]) |-> $past(pause_ack[u]))
            else begin
                fail_count++;
                $error("pause_req dropped before pause_ack");
            end

        rst_quiescent: assert property (@(posedge clk) disable iff (!arst_n)
            unit_rst[u] |-> pause_ack[u])
            else begin
                fail_count++;
                $error("unit_rst high on a unit that is not paused");
            end
    end

endmodule

bind adam_syscfg adam_syscfg_properties #(
    .NO_UNITS (NO_UNITS)
) u_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_req   (cfg_req),
    .cfg_ack   (cfg_ack),
    .cfg_rsp   (cfg_rsp),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .unit_rst  (unit_rst)
);

`default_nettype wire

//--- tests/adam_syscfg_tb.sv
// syscfg testbench: unit models, host bus tasks, register reference model and checks
`default_nettype none

module adam_syscfg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NO_UNITS       = 4;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                           clk;
    logic                           arst_n;
    logic                           cfg_req;
    adam_pkg::cfg_cmd_t             cfg_cmd;
    logic                           cfg_ack;
    adam_pkg::cfg_rsp_t             cfg_rsp;
    logic            [NO_UNITS-1:0] pause_req;
    logic            [NO_UNITS-1:0] pause_ack;
    logic            [NO_UNITS-1:0] unit_rst;
    adam_pkg::addr_t [NO_UNITS-1:0] unit_boot_addr;
    logic            [NO_UNITS-1:0] unit_irq;
    logic                           host_irq;

    // register model
    logic [1:0]      m_ctrl [NO_UNITS];
    adam_pkg::addr_t m_boot [NO_UNITS];
    logic            m_en   [NO_UNITS];
    logic            m_pend [NO_UNITS];

    int cycles = 0;

    adam_syscfg #(
        .NO_UNITS (NO_UNITS)
    ) UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_req        (cfg_req),
        .cfg_cmd        (cfg_cmd),
        .cfg_ack        (cfg_ack),
        .cfg_rsp        (cfg_rsp),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .unit_rst       (unit_rst),
        .unit_boot_addr (unit_boot_addr),
        .unit_irq       (unit_irq),
        .host_irq       (host_irq)
    );

    always #20 clk = ~clk;

    // unit models, ack follows req after 0 to 5 cycles
    for (genvar u = 0; u < NO_UNITS; u++) begin : g_unit_model
        logic ack;
        int   delay;
        assign pause_ack[u] = ack;
        initial begin
            ack = 1'b0;
            forever begin
                @(posedge clk);
                #5;
                if (pause_req[u] != ack) begin
                    delay = $urandom % 6;
                    repeat (delay) begin
                        @(posedge clk);
                        #5;
                    end
                    ack = pause_req[u];
                end
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (UUT.u_properties.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic check_rsp(input string name, input adam_pkg::cfg_rsp_t exp,
                             input adam_pkg::cfg_rsp_t act);
        if (exp !== act) begin
            abort_run($sformatf("Error: %s expected rdata %h err %b actual rdata %h err %b",
                                name, exp.rdata, exp.err, act.rdata, act.err));
        end
    endtask

    task automatic check_addr(input string name, input adam_pkg::addr_t exp,
                              input adam_pkg::addr_t act);
        if (exp !== act) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic adam_pkg::addr_t reg_addr(input int u, input adam_pkg::cfg_reg_e r);
        return adam_pkg::addr_t'(u * 4 + int'(r));
    endfunction

    // expected response of a read, status from the settled control bits
    function automatic adam_pkg::cfg_rsp_t ref_read(input adam_pkg::addr_t addr);
        adam_pkg::cfg_rsp_t rsp;
        int                 u;
        rsp = '0;
        u   = int'(addr[adam_pkg::ADDR_WIDTH-1:2]);
        if (addr[adam_pkg::ADDR_WIDTH-1:2] >= NO_UNITS) begin
            rsp.err = 1'b1;
        end else begin
            case (adam_pkg::cfg_reg_e'(addr[1:0]))
                adam_pkg::REG_CTRL:   rsp.rdata[1:0] = m_ctrl[u];
                adam_pkg::REG_STATUS: rsp.rdata[1:0] = {|m_ctrl[u], m_ctrl[u][0]};
                adam_pkg::REG_BOOT:   rsp.rdata      = m_boot[u];
                default:              rsp.rdata[1:0] = {m_pend[u], m_en[u]};
            endcase
        end
        return rsp;
    endfunction

    // updates the model and returns the expected write response
    function automatic adam_pkg::cfg_rsp_t ref_write(input adam_pkg::addr_t addr,
                                                     input adam_pkg::data_t data);
        adam_pkg::cfg_rsp_t rsp;
        adam_pkg::cfg_reg_e r;
        int                 u;
        rsp = '0;
        r   = adam_pkg::cfg_reg_e'(addr[1:0]);
        u   = int'(addr[adam_pkg::ADDR_WIDTH-1:2]);
        if (addr[adam_pkg::ADDR_WIDTH-1:2] >= NO_UNITS || r == adam_pkg::REG_STATUS) begin
            rsp.err = 1'b1;
        end else if (r == adam_pkg::REG_CTRL) begin
            m_ctrl[u] = data[1:0];
        end else if (r == adam_pkg::REG_BOOT) begin
            m_boot[u] = data;
        end else begin
            m_en[u] = data[0];
            if (data[1]) begin
                m_pend[u] = 1'b0;
            end
        end
        return rsp;
    endfunction

    function automatic logic ref_host_irq();
        logic any;
        any = 1'b0;
        for (int i = 0; i < NO_UNITS; i++) begin
            any = any | (m_en[i] & m_pend[i]);
        end
        return any;
    endfunction

    // one four-phase access, called 5 ns after a rising edge
    task automatic bus_access(input adam_pkg::cfg_op_e op, input adam_pkg::addr_t addr,
                              input adam_pkg::data_t data, output adam_pkg::cfg_rsp_t rsp);
        int hold;
        cfg_cmd.op    = op;
        cfg_cmd.addr  = addr;
        cfg_cmd.wdata = data;
        cfg_req       = 1'b1;
        do begin
            @(posedge clk);
            #5;
        end while (!cfg_ack);
        rsp = cfg_rsp;
        // host may keep req up a while, ack has to stay with it
        hold = $urandom % 2;
        repeat (hold) begin
            @(posedge clk);
            #5;
            check_bit("cfg_ack held with cfg_req", 1'b1, cfg_ack);
        end
        cfg_req = 1'b0;
        do begin
            @(posedge clk);
            #5;
        end while (cfg_ack);
    endtask

    task automatic cfg_write(input string name, input adam_pkg::addr_t addr,
                             input adam_pkg::data_t data);
        adam_pkg::cfg_rsp_t rsp;
        bus_access(adam_pkg::CFG_WRITE, addr, data, rsp);
        check_rsp(name, ref_write(addr, data), rsp);
    endtask

    task automatic cfg_read(input string name, input adam_pkg::addr_t addr);
        adam_pkg::cfg_rsp_t rsp;
        bus_access(adam_pkg::CFG_READ, addr, '0, rsp);
        check_rsp(name, ref_read(addr), rsp);
    endtask

    task automatic poll_status(input int u, input int bit_idx, input logic want);
        adam_pkg::cfg_rsp_t rsp;
        do begin
            bus_access(adam_pkg::CFG_READ, reg_addr(u, adam_pkg::REG_STATUS), '0, rsp);
        end while (rsp.rdata[bit_idx] !== want);
    endtask

    initial begin
        int   u;
        logic seen_ack;
        void'($urandom(49));
        clk      = 1'b0;
        arst_n   = 1'b0;
        cfg_req  = 1'b0;
        cfg_cmd  = '0;
        unit_irq = '0;
        for (int i = 0; i < NO_UNITS; i++) begin
            m_ctrl[i] = '0;
            m_boot[i] = '0;
            m_en[i]   = 1'b0;
            m_pend[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        check_bit("cfg_ack after reset", 1'b0, cfg_ack);
        check_bit("host_irq after reset", 1'b0, host_irq);
        for (int i = 0; i < NO_UNITS; i++) begin
            check_bit("pause_req after reset", 1'b0, pause_req[i]);
            check_bit("unit_rst after reset", 1'b0, unit_rst[i]);
        end

        // random boot and enable traffic
        for (int n = 0; n < 12; n++) begin
            u = $urandom % NO_UNITS;
            cfg_write("boot write", reg_addr(u, adam_pkg::REG_BOOT), $urandom);
            cfg_write("irq enable write", reg_addr(u, adam_pkg::REG_IRQ), $urandom % 2);
            cfg_read("boot readback", reg_addr(u, adam_pkg::REG_BOOT));
            cfg_read("irq enable readback", reg_addr(u, adam_pkg::REG_IRQ));
        end
        for (int i = 0; i < NO_UNITS; i++) begin
            check_addr("boot port", m_boot[i], unit_boot_addr[i]);
        end

        // pause and resume unit 1
        cfg_write("pause set", reg_addr(1, adam_pkg::REG_CTRL), 32'h2);
        poll_status(1, 1, 1'b1);
        check_bit("pause_req while paused", 1'b1, pause_req[1]);
        cfg_read("status paused", reg_addr(1, adam_pkg::REG_STATUS));
        cfg_write("pause clear", reg_addr(1, adam_pkg::REG_CTRL), 32'h0);
        poll_status(1, 1, 1'b0);
        check_bit("pause_req after resume", 1'b0, pause_req[1]);

        // reset unit 2, no reset before the unit is quiescent
        cfg_write("reset set", reg_addr(2, adam_pkg::REG_CTRL), 32'h1);
        seen_ack = 1'b0;
        while (!seen_ack) begin
            @(negedge clk);
            check_bit("unit_rst before pause_ack", 1'b0, unit_rst[2]);
            seen_ack = pause_ack[2];
        end
        @(posedge clk);
        #5;
        poll_status(2, 0, 1'b1);
        cfg_read("status in reset", reg_addr(2, adam_pkg::REG_STATUS));
        check_bit("unit_rst while in reset", 1'b1, unit_rst[2]);
        cfg_write("reset clear", reg_addr(2, adam_pkg::REG_CTRL), 32'h0);
        check_bit("unit_rst after clear", 1'b0, unit_rst[2]);
        poll_status(2, 1, 1'b0);
        while (pause_ack[2]) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        check_bit("pause_req after reset", 1'b0, pause_req[2]);

        // unit 0 enabled, unit 3 masked
        cfg_write("irq enable", reg_addr(0, adam_pkg::REG_IRQ), 32'h1);
        cfg_write("irq disable", reg_addr(3, adam_pkg::REG_IRQ), 32'h0);
        unit_irq[0] = 1'b1;
        unit_irq[3] = 1'b1;
        m_pend[0]   = 1'b1;
        m_pend[3]   = 1'b1;
        @(posedge clk);
        #5;
        unit_irq = '0;
        @(posedge clk);
        #5;
        check_bit("host_irq after pulse", ref_host_irq(), host_irq);
        cfg_read("pending enabled unit", reg_addr(0, adam_pkg::REG_IRQ));
        cfg_read("pending masked unit", reg_addr(3, adam_pkg::REG_IRQ));
        cfg_write("pending clear", reg_addr(0, adam_pkg::REG_IRQ), 32'h3);
        check_bit("host_irq after clear", ref_host_irq(), host_irq);
        cfg_write("masked clear", reg_addr(3, adam_pkg::REG_IRQ), 32'h2);
        cfg_read("pending cleared", reg_addr(0, adam_pkg::REG_IRQ));
        cfg_read("masked cleared", reg_addr(3, adam_pkg::REG_IRQ));

        // bad accesses leave every register alone
        cfg_read("bad unit read", reg_addr(NO_UNITS, adam_pkg::REG_BOOT));
        cfg_read("bad unit read high", reg_addr(15, adam_pkg::REG_CTRL));
        cfg_write("bad unit write", reg_addr(NO_UNITS + 1, adam_pkg::REG_BOOT), 32'hdead_beef);
        cfg_write("status write", reg_addr(1, adam_pkg::REG_STATUS), 32'h3);
        for (int i = 0; i < NO_UNITS; i++) begin
            for (int r = 0; r < 4; r++) begin
                cfg_read("readback after errors", reg_addr(i, adam_pkg::cfg_reg_e'(r)));
            end
            check_addr("boot port after errors", m_boot[i], unit_boot_addr[i]);
        end

        if (UUT.u_properties.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/adam_pkg.sv
rtl/adam_pause_ctrl.sv
rtl/adam_irq_ctrl.sv
rtl/adam_syscfg_regs.sv
rtl/adam_syscfg.sv
tests/adam_syscfg_properties.sv
tests/adam_syscfg_tb.sv

//--- Makefile
# Verilator build, run and lint for the syscfg testbench

VERILATOR ?= verilator
TOP       ?= adam_syscfg_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
